/* rtl/wdp_params.svh */
// datapath sizes; WDP_MEM_DQ_WIDTH must equal groups times DQ per group, and OCT_EXTEND must not exceed RATE
`ifndef WDP_PARAMS_SVH
`define WDP_PARAMS_SVH

// ********************
// memory side
// ********************

// DQ pins on the memory interface
`define WDP_MEM_DQ_WIDTH 16
// number of write DQS groups
`define WDP_DQS_GROUPS 2
// DQ and DM pins carried by one DQS group
`define WDP_DQ_PER_GROUP 8
`define WDP_DM_PER_GROUP 1
// DM pins over all groups
`define WDP_MEM_DM_WIDTH (`WDP_DQS_GROUPS * `WDP_DM_PER_GROUP)

// ********************
// AFI side
// ********************

// full-rate slots in one AFI word, two DDR beats per slot
`define WDP_RATE 4
`define WDP_BEATS (2 * `WDP_RATE)
// flop stages on the input side, 1 or more
`define WDP_FLOP_STAGES 2
// slots the OCT source stays asserted after the last dqs_en slot
`define WDP_OCT_EXTEND 2
// width of one group's slot delay setting
`define WDP_SHIFT_WIDTH 2

`endif

/* rtl/wdp_pkg.sv */
// vector types of the write datapath; all AFI buses are beat-major or slot-major with group inside
`include "wdp_params.svh"

package wdp_pkg;

	// ********************
	// full AFI word
	// ********************

	// eight beats of all DQ pins, beat 0 in the low bits
	typedef logic [`WDP_MEM_DQ_WIDTH*`WDP_BEATS-1:0] afi_data_t;

	// byte mask in the same beat-major order as the data
	typedef logic [`WDP_MEM_DM_WIDTH*`WDP_BEATS-1:0] afi_mask_t;

	// one bit per slot per group, bit = group + groups * slot
	typedef logic [`WDP_DQS_GROUPS*`WDP_RATE-1:0] afi_ctl_t;

	// ********************
	// one DQS group
	// ********************

	// eight beats of the group's DQ pins
	typedef logic [`WDP_DQ_PER_GROUP*`WDP_BEATS-1:0] grp_data_t;

	typedef logic [`WDP_DM_PER_GROUP*`WDP_BEATS-1:0] grp_mask_t;

	// one control bit per full-rate slot
	typedef logic [`WDP_RATE-1:0] grp_ctl_t;

	// ********************
	// calibration setting
	// ********************

	// delay in full-rate slots, 0 to 3
	typedef logic [`WDP_SHIFT_WIDTH-1:0] slot_shift_t;

	// every group's delay, group 0 in the low bits
	typedef logic [`WDP_SHIFT_WIDTH*`WDP_DQS_GROUPS-1:0] shift_cfg_t;

endpackage

/* rtl/wdp_input_pipe.sv */
// fixed latency of WDP_FLOP_STAGES cycles; the shift setting may only be loaded while no write is in the chain
`timescale 1ns/1ps
`include "wdp_params.svh"

module wdp_input_pipe
(
	input  logic                   pll_afi_clk,
	input  logic                   arst_n,
	input  wdp_pkg::afi_data_t     afi_wdata,
	input  wdp_pkg::afi_mask_t     afi_dm,
	input  wdp_pkg::afi_ctl_t      afi_wdata_valid,
	input  wdp_pkg::afi_ctl_t      afi_dqs_en,
	input  wdp_pkg::shift_cfg_t    seq_wr_shift,
	input  logic                   seq_wr_shift_load,
	output wdp_pkg::afi_data_t     pipe_dq,
	output wdp_pkg::afi_mask_t     pipe_dm,
	output wdp_pkg::afi_ctl_t      pipe_wen,
	output wdp_pkg::afi_ctl_t      pipe_dqs_en,
	output wdp_pkg::afi_ctl_t      pipe_oct,
	output wdp_pkg::shift_cfg_t    grp_shift
);

	localparam int STAGES = `WDP_FLOP_STAGES;
	localparam int GROUPS = `WDP_DQS_GROUPS;
	localparam int RATE   = `WDP_RATE;

	wdp_pkg::afi_data_t  dq_r  [STAGES];
	wdp_pkg::afi_mask_t  dm_r  [STAGES];
	wdp_pkg::afi_ctl_t   wen_r [STAGES];
	wdp_pkg::afi_ctl_t   dqs_r [STAGES];
	wdp_pkg::afi_ctl_t   oct_q;
	wdp_pkg::afi_ctl_t   dqs_last_in;
	wdp_pkg::shift_cfg_t shift_q;
	logic                chain_busy;

	// OR each slot's dqs_en with the OCT_EXTEND slots before it, looking back into the previous word
	function automatic wdp_pkg::afi_ctl_t oct_extend(wdp_pkg::afi_ctl_t cur,
		wdp_pkg::afi_ctl_t prev);
		logic [2*GROUPS*RATE-1:0] stream;
		wdp_pkg::afi_ctl_t        res;
		stream = {cur, prev};
		res = '0;
		for (int s = 0; s < RATE; s++)
		begin
			for (int g = 0; g < GROUPS; g++)
			begin
				for (int e = 0; e <= `WDP_OCT_EXTEND; e++)
				begin
					res[g + GROUPS*s] = res[g + GROUPS*s] | stream[g + GROUPS*(s + RATE - e)];
				end
			end
		end
		return res;
	endfunction

	// dqs_en that enters the last stage on this edge
	generate
		if (STAGES == 1)
		begin : g_single
			assign dqs_last_in = afi_dqs_en;
		end
		else
		begin : g_multi
			assign dqs_last_in = dqs_r[STAGES-2];
		end
	endgenerate

	// ********************
	// register chain
	// ********************

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int s = 0; s < STAGES; s++)
			begin
				dq_r[s]  <= '0;
				dm_r[s]  <= '0;
				wen_r[s] <= '0;
				dqs_r[s] <= '0;
			end
			oct_q <= '0;
		end
		else
		begin
			dq_r[0]  <= afi_wdata;
			dm_r[0]  <= afi_dm;
			wen_r[0] <= afi_wdata_valid;
			dqs_r[0] <= afi_dqs_en;
			for (int s = 1; s < STAGES; s++)
			begin
				dq_r[s]  <= dq_r[s-1];
				dm_r[s]  <= dm_r[s-1];
				wen_r[s] <= wen_r[s-1];
				dqs_r[s] <= dqs_r[s-1];
			end
			// the last stage still holds the previous word, which is the history for the extension
			oct_q <= oct_extend(dqs_last_in, dqs_r[STAGES-1]);
		end
	end

	// per-group slot delay from the calibration sequencer
	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
			shift_q <= '0;
		else if (seq_wr_shift_load)
			shift_q <= seq_wr_shift;
	end

	assign pipe_dq     = dq_r[STAGES-1];
	assign pipe_dm     = dm_r[STAGES-1];
	assign pipe_wen    = wen_r[STAGES-1];
	assign pipe_dqs_en = dqs_r[STAGES-1];
	assign pipe_oct    = oct_q;
	assign grp_shift   = shift_q;

	always_comb
	begin
		chain_busy = 1'b0;
		for (int s = 0; s < STAGES; s++)
		begin
			chain_busy = chain_busy | (|wen_r[s]) | (|dqs_r[s]);
		end
	end

	// a new delay must not split a burst that is already on its way to the shifters
	a_shift_load_idle: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		seq_wr_shift_load |-> !chain_busy)
		else $error("shift setting loaded while a write is in the input chain");

endmodule

/* rtl/wdp_group_shifter.sv */
// delays one DQS group by 0 to 3 full-rate slots with one cycle of latency; shift must be stable during a burst
`timescale 1ns/1ps
`include "wdp_params.svh"

module wdp_group_shifter
(
	input  logic                 pll_afi_clk,
	input  logic                 arst_n,
	input  wdp_pkg::slot_shift_t shift,
	input  wdp_pkg::grp_data_t   grp_dq_in,
	input  wdp_pkg::grp_mask_t   grp_dm_in,
	input  wdp_pkg::grp_ctl_t    grp_wen_in,
	input  wdp_pkg::grp_ctl_t    grp_dqs_en_in,
	input  wdp_pkg::grp_ctl_t    grp_oct_in,
	output wdp_pkg::grp_data_t   grp_dq_out,
	output wdp_pkg::grp_mask_t   grp_dm_out,
	output wdp_pkg::grp_ctl_t    grp_wen_out,
	output wdp_pkg::grp_ctl_t    grp_dqs_en_out,
	output wdp_pkg::grp_ctl_t    grp_oct_out
);

	localparam int RATE    = `WDP_RATE;
	localparam int SLOT_DQ = 2 * `WDP_DQ_PER_GROUP;
	localparam int SLOT_DM = 2 * `WDP_DM_PER_GROUP;

	// previous word of every field
	wdp_pkg::grp_data_t dq_prev_q;
	wdp_pkg::grp_mask_t dm_prev_q;
	wdp_pkg::grp_ctl_t  wen_prev_q;
	wdp_pkg::grp_ctl_t  dqs_prev_q;
	wdp_pkg::grp_ctl_t  oct_prev_q;

	// current word above previous word, so slot p of the stream sits at p * slot width
	logic [2*$bits(wdp_pkg::grp_data_t)-1:0] dq_cat;
	logic [2*$bits(wdp_pkg::grp_mask_t)-1:0] dm_cat;
	logic [2*RATE-1:0]                       wen_cat;
	logic [2*RATE-1:0]                       dqs_cat;
	logic [2*RATE-1:0]                       oct_cat;

	wdp_pkg::grp_data_t dq_win;
	wdp_pkg::grp_mask_t dm_win;
	wdp_pkg::grp_ctl_t  wen_win;
	wdp_pkg::grp_ctl_t  dqs_win;
	wdp_pkg::grp_ctl_t  oct_win;

	assign dq_cat  = {grp_dq_in, dq_prev_q};
	assign dm_cat  = {grp_dm_in, dm_prev_q};
	assign wen_cat = {grp_wen_in, wen_prev_q};
	assign dqs_cat = {grp_dqs_en_in, dqs_prev_q};
	assign oct_cat = {grp_oct_in, oct_prev_q};

	// output slot t takes stream slot t + RATE - shift
	always_comb
	begin
		int base;
		base    = RATE - int'(shift);
		dq_win  = dq_cat[base*SLOT_DQ +: RATE*SLOT_DQ];
		dm_win  = dm_cat[base*SLOT_DM +: RATE*SLOT_DM];
		wen_win = wen_cat[base +: RATE];
		dqs_win = dqs_cat[base +: RATE];
		oct_win = oct_cat[base +: RATE];
	end

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dq_prev_q      <= '0;
			dm_prev_q      <= '0;
			wen_prev_q     <= '0;
			dqs_prev_q     <= '0;
			oct_prev_q     <= '0;
			grp_dq_out     <= '0;
			grp_dm_out     <= '0;
			grp_wen_out    <= '0;
			grp_dqs_en_out <= '0;
			grp_oct_out    <= '0;
		end
		else
		begin
			dq_prev_q      <= grp_dq_in;
			dm_prev_q      <= grp_dm_in;
			wen_prev_q     <= grp_wen_in;
			dqs_prev_q     <= grp_dqs_en_in;
			oct_prev_q     <= grp_oct_in;
			grp_dq_out     <= dq_win;
			grp_dm_out     <= dm_win;
			grp_wen_out    <= wen_win;
			grp_dqs_en_out <= dqs_win;
			grp_oct_out    <= oct_win;
		end
	end

	// the setting comes from the sequencer through the input pipe and must be driven after reset
	a_shift_known: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		!$isunknown(shift))
		else $error("group slot shift is unknown");

endmodule

/* rtl/wdp_output_stage.sv */
// one registered cycle to the DDIO bus; oct_ena resets to all ones so termination is on while idle
`timescale 1ns/1ps
`include "wdp_params.svh"

module wdp_output_stage
(
	input  logic               pll_afi_clk,
	input  logic               arst_n,
	input  wdp_pkg::afi_ctl_t  force_oct_off,
	input  wdp_pkg::grp_data_t sh_dq     [`WDP_DQS_GROUPS],
	input  wdp_pkg::grp_mask_t sh_dm     [`WDP_DQS_GROUPS],
	input  wdp_pkg::grp_ctl_t  sh_wen    [`WDP_DQS_GROUPS],
	input  wdp_pkg::grp_ctl_t  sh_dqs_en [`WDP_DQS_GROUPS],
	input  wdp_pkg::grp_ctl_t  sh_oct    [`WDP_DQS_GROUPS],
	output wdp_pkg::afi_data_t phy_ddio_dq,
	output wdp_pkg::afi_mask_t phy_ddio_wrdata_mask,
	output wdp_pkg::afi_ctl_t  phy_ddio_wrdata_en,
	output wdp_pkg::afi_ctl_t  phy_ddio_dqs_en,
	output wdp_pkg::afi_ctl_t  phy_ddio_oct_ena
);

	localparam int GROUPS = `WDP_DQS_GROUPS;
	localparam int DQ_G   = `WDP_DQ_PER_GROUP;
	localparam int DM_G   = `WDP_DM_PER_GROUP;

	wdp_pkg::afi_data_t dq_nxt;
	wdp_pkg::afi_mask_t dm_nxt;
	wdp_pkg::afi_ctl_t  wen_nxt;
	wdp_pkg::afi_ctl_t  dqs_nxt;
	wdp_pkg::afi_ctl_t  oct_src;

	// ********************
	// back to bus order
	// ********************

	always_comb
	begin
		dq_nxt  = '0;
		dm_nxt  = '0;
		wen_nxt = '0;
		dqs_nxt = '0;
		oct_src = '0;
		for (int g = 0; g < GROUPS; g++)
		begin
			for (int t = 0; t < `WDP_BEATS; t++)
			begin
				dq_nxt[DQ_G*g + `WDP_MEM_DQ_WIDTH*t +: DQ_G] = sh_dq[g][t*DQ_G +: DQ_G];
				dm_nxt[DM_G*g + `WDP_MEM_DM_WIDTH*t +: DM_G] = sh_dm[g][t*DM_G +: DM_G];
			end
			for (int s = 0; s < `WDP_RATE; s++)
			begin
				wen_nxt[g + GROUPS*s] = sh_wen[g][s];
				dqs_nxt[g + GROUPS*s] = sh_dqs_en[g][s];
				oct_src[g + GROUPS*s] = sh_oct[g][s];
			end
		end
	end

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phy_ddio_dq          <= '0;
			phy_ddio_wrdata_mask <= '0;
			phy_ddio_wrdata_en   <= '0;
			phy_ddio_dqs_en      <= '0;
			phy_ddio_oct_ena     <= '1;
		end
		else
		begin
			phy_ddio_dq          <= dq_nxt;
			phy_ddio_wrdata_mask <= dm_nxt;
			phy_ddio_wrdata_en   <= wen_nxt;
			phy_ddio_dqs_en      <= dqs_nxt;
			// termination stays on only outside a write burst and while it is not forced off
			phy_ddio_oct_ena     <= ~oct_src & ~force_oct_off;
		end
	end

	// data is never driven on a slot whose strobe is not running
	a_wen_has_dqs: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		(phy_ddio_wrdata_en & ~phy_ddio_dqs_en) == '0)
		else $error("wrdata_en slot without dqs_en");

endmodule

/* rtl/write_datapath.sv */
// quarter-rate DDR3 write datapath; latency is WDP_FLOP_STAGES+2 cycles plus the per-group slot shift
`timescale 1ns/1ps
`include "wdp_params.svh"

module write_datapath
(
	input  logic                pll_afi_clk,
	input  logic                arst_n,
	input  wdp_pkg::afi_data_t  afi_wdata,
	input  wdp_pkg::afi_mask_t  afi_dm,
	input  wdp_pkg::afi_ctl_t   afi_wdata_valid,
	input  wdp_pkg::afi_ctl_t   afi_dqs_en,
	input  wdp_pkg::afi_ctl_t   force_oct_off,
	input  wdp_pkg::shift_cfg_t seq_wr_shift,
	input  logic                seq_wr_shift_load,
	output wdp_pkg::afi_data_t  phy_ddio_dq,
	output wdp_pkg::afi_mask_t  phy_ddio_wrdata_mask,
	output wdp_pkg::afi_ctl_t   phy_ddio_wrdata_en,
	output wdp_pkg::afi_ctl_t   phy_ddio_dqs_en,
	output wdp_pkg::afi_ctl_t   phy_ddio_oct_ena
);

	localparam int GROUPS = `WDP_DQS_GROUPS;
	localparam int DQ_G   = `WDP_DQ_PER_GROUP;
	localparam int DM_G   = `WDP_DM_PER_GROUP;

	wdp_pkg::afi_data_t  pipe_dq;
	wdp_pkg::afi_mask_t  pipe_dm;
	wdp_pkg::afi_ctl_t   pipe_wen;
	wdp_pkg::afi_ctl_t   pipe_dqs_en;
	wdp_pkg::afi_ctl_t   pipe_oct;
	wdp_pkg::shift_cfg_t grp_shift;

	wdp_pkg::grp_data_t sh_dq     [GROUPS];
	wdp_pkg::grp_mask_t sh_dm     [GROUPS];
	wdp_pkg::grp_ctl_t  sh_wen    [GROUPS];
	wdp_pkg::grp_ctl_t  sh_dqs_en [GROUPS];
	wdp_pkg::grp_ctl_t  sh_oct    [GROUPS];

	wdp_input_pipe u_pipe
	(
		.pll_afi_clk       (pll_afi_clk),
		.arst_n            (arst_n),
		.afi_wdata         (afi_wdata),
		.afi_dm            (afi_dm),
		.afi_wdata_valid   (afi_wdata_valid),
		.afi_dqs_en        (afi_dqs_en),
		.seq_wr_shift      (seq_wr_shift),
		.seq_wr_shift_load (seq_wr_shift_load),
		.pipe_dq           (pipe_dq),
		.pipe_dm           (pipe_dm),
		.pipe_wen          (pipe_wen),
		.pipe_dqs_en       (pipe_dqs_en),
		.pipe_oct          (pipe_oct),
		.grp_shift         (grp_shift)
	);

	// ********************
	// per-group shifters
	// ********************

	for (genvar g = 0; g < GROUPS; g++)
	begin : grp_gen
		wdp_pkg::grp_data_t grp_dq;
		wdp_pkg::grp_mask_t grp_dm;
		wdp_pkg::grp_ctl_t  grp_wen;
		wdp_pkg::grp_ctl_t  grp_dqs_en;
		wdp_pkg::grp_ctl_t  grp_oct;

		// gather this group's lanes out of every beat
		for (genvar t = 0; t < `WDP_BEATS; t++)
		begin : beat_gen
			assign grp_dq[t*DQ_G +: DQ_G] = pipe_dq[DQ_G*g + `WDP_MEM_DQ_WIDTH*t +: DQ_G];
			assign grp_dm[t*DM_G +: DM_G] = pipe_dm[DM_G*g + `WDP_MEM_DM_WIDTH*t +: DM_G];
		end

		for (genvar s = 0; s < `WDP_RATE; s++)
		begin : slot_gen
			assign grp_wen[s]    = pipe_wen[g + GROUPS*s];
			assign grp_dqs_en[s] = pipe_dqs_en[g + GROUPS*s];
			assign grp_oct[s]    = pipe_oct[g + GROUPS*s];
		end

		wdp_group_shifter u_shifter
		(
			.pll_afi_clk    (pll_afi_clk),
			.arst_n         (arst_n),
			.shift          (grp_shift[g*`WDP_SHIFT_WIDTH +: `WDP_SHIFT_WIDTH]),
			.grp_dq_in      (grp_dq),
			.grp_dm_in      (grp_dm),
			.grp_wen_in     (grp_wen),
			.grp_dqs_en_in  (grp_dqs_en),
			.grp_oct_in     (grp_oct),
			.grp_dq_out     (sh_dq[g]),
			.grp_dm_out     (sh_dm[g]),
			.grp_wen_out    (sh_wen[g]),
			.grp_dqs_en_out (sh_dqs_en[g]),
			.grp_oct_out    (sh_oct[g])
		);
	end

	wdp_output_stage u_out
	(
		.pll_afi_clk          (pll_afi_clk),
		.arst_n               (arst_n),
		.force_oct_off        (force_oct_off),
		.sh_dq                (sh_dq),
		.sh_dm                (sh_dm),
		.sh_wen               (sh_wen),
		.sh_dqs_en            (sh_dqs_en),
		.sh_oct               (sh_oct),
		.phy_ddio_dq          (phy_ddio_dq),
		.phy_ddio_wrdata_mask (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en   (phy_ddio_wrdata_en),
		.phy_ddio_dqs_en      (phy_ddio_dqs_en),
		.phy_ddio_oct_ena     (phy_ddio_oct_ena)
	);

endmodule

/* dv/tb_write_datapath.sv */
// testbench for write_datapath; expects WDP_OCT_EXTEND below WDP_RATE and loads shifts only in idle gaps
`timescale 1ns/1ps
`include "wdp_params.svh"

module tb_write_datapath;

	localparam int GROUPS      = `WDP_DQS_GROUPS;
	localparam int RATE        = `WDP_RATE;
	localparam int DQ_G        = `WDP_DQ_PER_GROUP;
	localparam int DM_G        = `WDP_DM_PER_GROUP;
	localparam int DQ_W        = `WDP_MEM_DQ_WIDTH;
	localparam int DM_W        = `WDP_MEM_DM_WIDTH;
	localparam int SW          = `WDP_SHIFT_WIDTH;
	localparam int LAT         = `WDP_FLOP_STAGES + 2;
	localparam int RST_CYCLES  = 5;
	localparam int IDLE_LEN    = 8;
	localparam int ZERO_LEN    = 40;
	localparam int GAP_LEN     = 6;
	localparam int BURST_LEN   = 24;
	localparam int NUM_CFG     = 7;
	localparam int OCT_LEN     = 32;
	localparam int DRAIN_LEN   = LAT + 10;
	localparam int TEST_CYCLES = RST_CYCLES + IDLE_LEN + ZERO_LEN + NUM_CFG * (GAP_LEN + BURST_LEN)
		+ GAP_LEN + OCT_LEN + DRAIN_LEN;
	localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

	logic                pll_afi_clk = 1'b0;
	logic                arst_n;
	wdp_pkg::afi_data_t  afi_wdata;
	wdp_pkg::afi_mask_t  afi_dm;
	wdp_pkg::afi_ctl_t   afi_wdata_valid;
	wdp_pkg::afi_ctl_t   afi_dqs_en;
	wdp_pkg::afi_ctl_t   force_oct_off;
	wdp_pkg::shift_cfg_t seq_wr_shift;
	logic                seq_wr_shift_load;
	wdp_pkg::afi_data_t  phy_ddio_dq;
	wdp_pkg::afi_mask_t  phy_ddio_wrdata_mask;
	wdp_pkg::afi_ctl_t   phy_ddio_wrdata_en;
	wdp_pkg::afi_ctl_t   phy_ddio_dqs_en;
	wdp_pkg::afi_ctl_t   phy_ddio_oct_ena;

	// every driven word, indexed by the clock edge that drove it
	wdp_pkg::afi_data_t  q_data [$];
	wdp_pkg::afi_mask_t  q_dm   [$];
	wdp_pkg::afi_ctl_t   q_wen  [$];
	wdp_pkg::afi_ctl_t   q_dqs  [$];
	wdp_pkg::afi_ctl_t   q_frc  [$];
	logic                q_load [$];
	wdp_pkg::shift_cfg_t q_cfg  [$];

	int          drv_count   = 0;
	int          err_count   = 0;
	int          cycle_count = 0;
	logic [31:0] lfsr        = 32'he1e6;
	int          sh0 [NUM_CFG] = '{0, 1, 2, 3, 1, 3, 2};
	int          sh1 [NUM_CFG] = '{0, 1, 2, 3, 3, 0, 1};

	write_datapath dut0
	(
		.pll_afi_clk          (pll_afi_clk),
		.arst_n               (arst_n),
		.afi_wdata            (afi_wdata),
		.afi_dm               (afi_dm),
		.afi_wdata_valid      (afi_wdata_valid),
		.afi_dqs_en           (afi_dqs_en),
		.force_oct_off        (force_oct_off),
		.seq_wr_shift         (seq_wr_shift),
		.seq_wr_shift_load    (seq_wr_shift_load),
		.phy_ddio_dq          (phy_ddio_dq),
		.phy_ddio_wrdata_mask (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en   (phy_ddio_wrdata_en),
		.phy_ddio_dqs_en      (phy_ddio_dqs_en),
		.phy_ddio_oct_ena     (phy_ddio_oct_ena)
	);

	always #50 pll_afi_clk = ~pll_afi_clk;

	always @(posedge pll_afi_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout: stimulus still running after %0d cycles", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ********************
	// stimulus
	// ********************

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	function automatic wdp_pkg::shift_cfg_t cfg_of(input int s0, input int s1);
		return {wdp_pkg::slot_shift_t'(s1), wdp_pkg::slot_shift_t'(s0)};
	endfunction

	task automatic drive_word(input wdp_pkg::afi_data_t d, input wdp_pkg::afi_mask_t m,
		input wdp_pkg::afi_ctl_t wen, input wdp_pkg::afi_ctl_t dqs,
		input wdp_pkg::afi_ctl_t frc, input logic load, input wdp_pkg::shift_cfg_t cfg);
		@(posedge pll_afi_clk);
		afi_wdata         <= d;
		afi_dm            <= m;
		afi_wdata_valid   <= wen;
		afi_dqs_en        <= dqs;
		force_oct_off     <= frc;
		seq_wr_shift_load <= load;
		seq_wr_shift      <= cfg;
		q_data.push_back(d);
		q_dm.push_back(m);
		q_wen.push_back(wen);
		q_dqs.push_back(dqs);
		q_frc.push_back(frc);
		q_load.push_back(load);
		q_cfg.push_back(cfg);
		drv_count = drv_count + 1;
	endtask

	// idle words with the new shift loaded once the input chain has emptied
	task automatic load_gap(input wdp_pkg::shift_cfg_t cfg);
		for (int i = 0; i < GAP_LEN; i++)
		begin
			drive_word('0, '0, '0, '0, '0, (i == 3), cfg);
		end
	endtask

	// wdata_valid is kept inside dqs_en, as a controller would drive it
	task automatic random_word(input logic use_frc);
		wdp_pkg::afi_ctl_t dqs;
		wdp_pkg::afi_ctl_t frc;
		dqs = wdp_pkg::afi_ctl_t'(rand_bits(8));
		frc = use_frc ? wdp_pkg::afi_ctl_t'(rand_bits(8)) : '0;
		drive_word(wdp_pkg::afi_data_t'(rand_bits(128)), wdp_pkg::afi_mask_t'(rand_bits(16)),
			dqs & wdp_pkg::afi_ctl_t'(rand_bits(8)), dqs, frc, 1'b0, '0);
	endtask

	task automatic oct_word(input wdp_pkg::afi_ctl_t wen, input wdp_pkg::afi_ctl_t dqs);
		drive_word(wdp_pkg::afi_data_t'(rand_bits(128)), wdp_pkg::afi_mask_t'(rand_bits(16)),
			wen, dqs, wdp_pkg::afi_ctl_t'(rand_bits(8)), 1'b0, '0);
	endtask

	// ********************
	// reference model
	// ********************

	function automatic wdp_pkg::afi_data_t get_data(input int d);
		return (d < 0) ? '0 : q_data[d];
	endfunction

	function automatic wdp_pkg::afi_mask_t get_dm(input int d);
		return (d < 0) ? '0 : q_dm[d];
	endfunction

	function automatic wdp_pkg::afi_ctl_t get_wen(input int d);
		return (d < 0) ? '0 : q_wen[d];
	endfunction

	function automatic wdp_pkg::afi_ctl_t get_dqs(input int d);
		return (d < 0) ? '0 : q_dqs[d];
	endfunction

	function automatic wdp_pkg::afi_ctl_t get_frc(input int d);
		return (d < 0) ? '0 : q_frc[d];
	endfunction

	// the shifter sees word d with the last setting loaded no later than edge d+1
	function automatic wdp_pkg::shift_cfg_t shift_for_word(input int d);
		wdp_pkg::shift_cfg_t cfg;
		cfg = '0;
		for (int c = 0; c <= d + 1 && c < q_load.size(); c++)
		begin
			if (q_load[c])
				cfg = q_cfg[c];
		end
		return cfg;
	endfunction

	// dqs_en of a slot stretched over the following OCT_EXTEND slots
	function automatic wdp_pkg::afi_ctl_t oct_source(input int d);
		wdp_pkg::afi_ctl_t cur;
		wdp_pkg::afi_ctl_t prev;
		wdp_pkg::afi_ctl_t src;
		int                p;
		cur  = get_dqs(d);
		prev = get_dqs(d - 1);
		src  = '0;
		for (int g = 0; g < GROUPS; g++)
		begin
			for (int s = 0; s < RATE; s++)
			begin
				for (int e = 0; e <= `WDP_OCT_EXTEND; e++)
				begin
					p = s - e;
					if (p >= 0)
						src[g + GROUPS*s] = src[g + GROUPS*s] | cur[g + GROUPS*p];
					else
						src[g + GROUPS*s] = src[g + GROUPS*s] | prev[g + GROUPS*(p + RATE)];
				end
			end
		end
		return src;
	endfunction

	// outputs seen after edge n, built from word n-LAT and the word before it
	function automatic void expected_out(input int n, output wdp_pkg::afi_data_t dq,
		output wdp_pkg::afi_mask_t dm, output wdp_pkg::afi_ctl_t wen,
		output wdp_pkg::afi_ctl_t dqs, output wdp_pkg::afi_ctl_t oct_ena);
		wdp_pkg::shift_cfg_t cfg;
		wdp_pkg::afi_data_t  wd;
		wdp_pkg::afi_mask_t  wm;
		wdp_pkg::afi_ctl_t   ww;
		wdp_pkg::afi_ctl_t   wq;
		wdp_pkg::afi_ctl_t   wo;
		wdp_pkg::afi_ctl_t   oct_src;
		int                  d;
		int                  k;
		int                  sw;
		int                  ss;
		d       = n - LAT;
		cfg     = shift_for_word(d);
		dq      = '0;
		dm      = '0;
		wen     = '0;
		dqs     = '0;
		oct_src = '0;
		for (int g = 0; g < GROUPS; g++)
		begin
			k = int'(cfg[g*SW +: SW]);
			for (int t = 0; t < RATE; t++)
			begin
				sw = (t >= k) ? d : d - 1;
				ss = (t >= k) ? t - k : t - k + RATE;
				wd = get_data(sw);
				wm = get_dm(sw);
				ww = get_wen(sw);
				wq = get_dqs(sw);
				wo = oct_source(sw);
				for (int b = 0; b < 2; b++)
				begin
					dq[DQ_G*g + DQ_W*(2*t + b) +: DQ_G] = wd[DQ_G*g + DQ_W*(2*ss + b) +: DQ_G];
					dm[DM_G*g + DM_W*(2*t + b) +: DM_G] = wm[DM_G*g + DM_W*(2*ss + b) +: DM_G];
				end
				wen[g + GROUPS*t]     = ww[g + GROUPS*ss];
				dqs[g + GROUPS*t]     = wq[g + GROUPS*ss];
				oct_src[g + GROUPS*t] = wo[g + GROUPS*ss];
			end
		end
		oct_ena = ~oct_src & ~get_frc(n - 1);
	endfunction

	// ********************
	// compare
	// ********************

	always @(negedge pll_afi_clk)
	begin
		wdp_pkg::afi_data_t e_dq;
		wdp_pkg::afi_mask_t e_dm;
		wdp_pkg::afi_ctl_t  e_wen;
		wdp_pkg::afi_ctl_t  e_dqs;
		wdp_pkg::afi_ctl_t  e_oct;
		logic               check;
		check = 1'b0;
		if (!arst_n)
		begin
			e_dq  = '0;
			e_dm  = '0;
			e_wen = '0;
			e_dqs = '0;
			e_oct = '1;
			check = 1'b1;
		end
		else if (drv_count > 0)
		begin
			expected_out(drv_count - 1, e_dq, e_dm, e_wen, e_dqs, e_oct);
			check = 1'b1;
		end
		if (check)
		begin
			if (phy_ddio_dq !== e_dq)
			begin
				$display("MISMATCH time=%0t phy_ddio_dq expected=%h actual=%h",
					$time, e_dq, phy_ddio_dq);
				err_count++;
			end
			if (phy_ddio_wrdata_mask !== e_dm)
			begin
				$display("MISMATCH time=%0t phy_ddio_wrdata_mask expected=%h actual=%h",
					$time, e_dm, phy_ddio_wrdata_mask);
				err_count++;
			end
			if (phy_ddio_wrdata_en !== e_wen)
			begin
				$display("MISMATCH time=%0t phy_ddio_wrdata_en expected=%h actual=%h",
					$time, e_wen, phy_ddio_wrdata_en);
				err_count++;
			end
			if (phy_ddio_dqs_en !== e_dqs)
			begin
				$display("MISMATCH time=%0t phy_ddio_dqs_en expected=%h actual=%h",
					$time, e_dqs, phy_ddio_dqs_en);
				err_count++;
			end
			if (phy_ddio_oct_ena !== e_oct)
			begin
				$display("MISMATCH time=%0t phy_ddio_oct_ena expected=%h actual=%h",
					$time, e_oct, phy_ddio_oct_ena);
				err_count++;
			end
		end
	end

	initial
	begin
		wdp_pkg::afi_ctl_t one_hot;
		arst_n            <= 1'b0;
		afi_wdata         <= '0;
		afi_dm            <= '0;
		afi_wdata_valid   <= '0;
		afi_dqs_en        <= '0;
		force_oct_off     <= '0;
		seq_wr_shift      <= '0;
		seq_wr_shift_load <= 1'b0;
		repeat (RST_CYCLES) @(posedge pll_afi_clk);
		arst_n <= 1'b1;

		repeat (IDLE_LEN) drive_word('0, '0, '0, '0, '0, 1'b0, '0);
		// all groups still at shift 0 from reset
		repeat (ZERO_LEN) random_word(1'b0);
		for (int i = 0; i < NUM_CFG; i++)
		begin
			load_gap(cfg_of(sh0[i], sh1[i]));
			repeat (BURST_LEN) random_word(1'b0);
		end

		// single dqs_en slots, each followed by an idle word so the stretch shows on its own
		load_gap(cfg_of(2, 1));
		for (int s = 0; s < GROUPS * RATE; s++)
		begin
			one_hot    = '0;
			one_hot[s] = 1'b1;
			oct_word(one_hot, one_hot);
			oct_word('0, '0);
		end
		for (int i = 0; i < 8; i++)
		begin
			oct_word(wdp_pkg::afi_ctl_t'(rand_bits(8)), '1);
		end
		repeat (8) oct_word('0, '0);
		repeat (DRAIN_LEN) drive_word('0, '0, '0, '0, '0, 1'b0, '0);

		@(posedge pll_afi_clk);
		$display("checked %0d words, errors: %0d", drv_count, err_count);
		if (err_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* files.f */
+incdir+rtl
rtl/wdp_pkg.sv
rtl/wdp_input_pipe.sv
rtl/wdp_group_shifter.sv
rtl/wdp_output_stage.sv
rtl/write_datapath.sv
dv/tb_write_datapath.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run the write datapath testbench from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_write_datapath -f files.f \
	--Mdir obj_dir -o tb_write_datapath
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/tb_write_datapath > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	echo "no pass line found in sim.log"
	exit 1
fi
exit 0
